//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_width = 16;  // instruction and data word
    localparam int start_pc = 8;     // words 0..7 are the register file

    typedef logic [word_width-1:0] word_t;

    typedef enum logic [3:0] {
        op_move = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_mul  = 4'd3,
        op_in   = 4'd7,
        op_out  = 4'd8,
        op_stop = 4'd15
    } opcode_e;

    // first instruction word, msb first
    typedef struct packed {
        opcode_e    opcode;
        logic       a_ind;
        logic [2:0] a_reg;
        logic       b_ind;
        logic [2:0] b_reg;
        logic       c_ind;
        logic [2:0] c_reg;
    } instr_t;

    // source of the next memory address
    typedef enum logic [2:0] {
        as_pc,
        as_a_field,
        as_b_field,
        as_c_field,
        as_rdata,    // pointer just read from memory
        as_dest
    } addr_sel_e;

    typedef enum logic [1:0] {
        ws_b,
        ws_imm,
        ws_alu,
        ws_in
    } wdata_sel_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_mul
    } alu_op_e;

    typedef struct packed {
        logic       addr_ld;
        addr_sel_e  addr_sel;
        logic       we;
        wdata_sel_e wdata_sel;
        logic       a_ld;
        logic       a_from_field;  // direct A takes the register number itself
        logic       b_ld;
        logic       c_ld;
        alu_op_e    alu_op;
        logic       out_ld;
    } ctrl_t;

    typedef enum logic [4:0] {
        st_fetch,
        st_fetch_wait,
        st_ir,
        st_decode,
        st_imm_wait,
        st_imm,
        st_a,
        st_a_wait,
        st_a_ind,
        st_b,
        st_b_wait,
        st_b_dir,
        st_b_ind_wait,
        st_b_ind,
        st_c,
        st_c_wait,
        st_c_dir,
        st_c_ind_wait,
        st_c_ind,
        st_exec,
        st_write,
        st_out_req,
        st_out_wait,
        st_out,
        st_halt
    } state_e;

endpackage

`default_nettype wire

//--- design/instr_fetch.sv
`default_nettype none

module instr_fetch import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pc_inc,
    input  logic                  ir_ld,
    input  logic                  imm_ld,
    input  word_t                 mem_rdata,
    output instr_t                instr,
    output word_t                 imm,
    output logic [ADDR_WIDTH-1:0] pc
);

    instr_t ir_q;
    word_t  imm_q;
    logic [ADDR_WIDTH-1:0] pc_q;

    // program counter and instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= ADDR_WIDTH'(start_pc);
            ir_q <= '0;
        end else begin
            if (pc_inc) begin
                pc_q <= pc_q + 1'b1;  // wraps at the top of memory
            end
            if (ir_ld) begin
                ir_q <= mem_rdata;    // split into fields by instr_t
            end
        end
    end

    // second word of the immediate form
    always_ff @(posedge clk) begin
        if (imm_ld) begin
            imm_q <= mem_rdata;
        end
    end

    assign instr = ir_q;
    assign imm   = imm_q;
    assign pc    = pc_q;

endmodule

`default_nettype wire

//--- design/operand_unit.sv
`default_nettype none

module operand_unit import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ctrl_t                 ctrl,
    input  instr_t                instr,
    input  word_t                 imm,
    input  logic [ADDR_WIDTH-1:0] pc,
    input  word_t                 mem_rdata,
    input  word_t                 in_data,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic                  mem_we,
    output word_t                 mem_wdata,
    output word_t                 out_data
);

    logic [ADDR_WIDTH-1:0] a_q;     // destination address
    word_t b_q;
    word_t c_q;
    word_t alu_y;
    word_t wdata_d;
    logic [ADDR_WIDTH-1:0] addr_d;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub: alu_y = b_q - c_q;
            alu_mul: alu_y = b_q * c_q;  // low half only
            default: alu_y = b_q + c_q;
        endcase
    end

    // next memory address
    always_comb begin
        case (ctrl.addr_sel)
            as_a_field: addr_d = ADDR_WIDTH'(instr.a_reg);
            as_b_field: addr_d = ADDR_WIDTH'(instr.b_reg);
            as_c_field: addr_d = ADDR_WIDTH'(instr.c_reg);
            as_rdata:   addr_d = mem_rdata[ADDR_WIDTH-1:0];
            as_dest:    addr_d = a_q;
            default:    addr_d = pc;
        endcase
    end

    always_comb begin
        case (ctrl.wdata_sel)
            ws_imm:  wdata_d = imm;
            ws_alu:  wdata_d = alu_y;
            ws_in:   wdata_d = in_data;
            default: wdata_d = b_q;
        endcase
    end

    // memory interface and output port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_addr <= '0;
            mem_we   <= 1'b0;
            out_data <= '0;
        end else begin
            mem_we <= ctrl.we;  // one state of we gives one write cycle
            if (ctrl.addr_ld) begin
                mem_addr <= addr_d;
            end
            if (ctrl.out_ld) begin
                out_data <= mem_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.a_ld) begin
            if (ctrl.a_from_field) begin
                a_q <= ADDR_WIDTH'(instr.a_reg);
            end else begin
                a_q <= mem_rdata[ADDR_WIDTH-1:0];
            end
        end
        if (ctrl.b_ld) begin
            b_q <= mem_rdata;
        end
        if (ctrl.c_ld) begin
            c_q <= mem_rdata;
        end
        if (ctrl.we) begin
            mem_wdata <= wdata_d;
        end
    end

endmodule

`default_nettype wire

//--- design/cpu_control.sv
`default_nettype none

module cpu_control import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instr,
    output ctrl_t  ctrl,
    output logic   pc_inc,
    output logic   ir_ld,
    output logic   imm_ld,
    output logic   halted
);

    state_e state;
    state_e state_nx;
    state_e route_st;    // after decode and immediate word
    state_e after_a_st;
    state_e after_b_st;
    logic   imm_form;

    assign imm_form = ({instr.c_ind, instr.c_reg} == 4'b1000);

    // targets that only depend on the opcode
    always_comb begin
        case (instr.opcode)
            op_stop: route_st = st_halt;
            op_move, op_add, op_sub, op_mul, op_in, op_out: route_st = st_a;
            default: route_st = st_fetch;  // unused opcode does nothing
        endcase

        if (instr.opcode == op_out) begin
            after_a_st = st_out_req;
        end else if (instr.opcode == op_in || imm_form) begin
            after_a_st = st_exec;          // no B or C read
        end else begin
            after_a_st = st_b;
        end

        if (instr.opcode == op_move) begin
            after_b_st = st_exec;
        end else begin
            after_b_st = st_c;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_fetch;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        ctrl     = '0;
        pc_inc   = 1'b0;
        ir_ld    = 1'b0;
        imm_ld   = 1'b0;
        case (state)
            st_fetch: begin
                ctrl.addr_ld  = 1'b1;
                ctrl.addr_sel = as_pc;
                pc_inc        = 1'b1;
                state_nx      = st_fetch_wait;
            end
            st_fetch_wait: state_nx = st_ir;
            st_ir: begin
                ir_ld    = 1'b1;
                state_nx = st_decode;
            end
            st_decode: begin
                if (imm_form) begin
                    ctrl.addr_ld  = 1'b1;  // second word sits at pc
                    ctrl.addr_sel = as_pc;
                    pc_inc        = 1'b1;
                    state_nx      = st_imm_wait;
                end else begin
                    state_nx = route_st;
                end
            end
            st_imm_wait: state_nx = st_imm;
            st_imm: begin
                imm_ld   = 1'b1;
                state_nx = route_st;
            end
            st_a: begin
                if (instr.a_ind) begin
                    ctrl.addr_ld  = 1'b1;
                    ctrl.addr_sel = as_a_field;
                    state_nx      = st_a_wait;
                end else begin
                    ctrl.a_ld         = 1'b1;
                    ctrl.a_from_field = 1'b1;
                    state_nx          = after_a_st;
                end
            end
            st_a_wait: state_nx = st_a_ind;
            st_a_ind: begin
                ctrl.a_ld = 1'b1;  // destination held in the register word
                state_nx  = after_a_st;
            end
            st_b: begin
                ctrl.addr_ld  = 1'b1;
                ctrl.addr_sel = as_b_field;
                state_nx      = st_b_wait;
            end
            st_b_wait: state_nx = st_b_dir;
            st_b_dir: begin
                if (instr.b_ind) begin
                    ctrl.addr_ld  = 1'b1;  // follow the pointer
                    ctrl.addr_sel = as_rdata;
                    state_nx      = st_b_ind_wait;
                end else begin
                    ctrl.b_ld = 1'b1;
                    state_nx  = after_b_st;
                end
            end
            st_b_ind_wait: state_nx = st_b_ind;
            st_b_ind: begin
                ctrl.b_ld = 1'b1;
                state_nx  = after_b_st;
            end
            st_c: begin
                ctrl.addr_ld  = 1'b1;
                ctrl.addr_sel = as_c_field;
                state_nx      = st_c_wait;
            end
            st_c_wait: state_nx = st_c_dir;
            st_c_dir: begin
                if (instr.c_ind) begin
                    ctrl.addr_ld  = 1'b1;
                    ctrl.addr_sel = as_rdata;
                    state_nx      = st_c_ind_wait;
                end else begin
                    ctrl.c_ld = 1'b1;
                    state_nx  = st_exec;
                end
            end
            st_c_ind_wait: state_nx = st_c_ind;
            st_c_ind: begin
                ctrl.c_ld = 1'b1;
                state_nx  = st_exec;
            end
            st_exec: begin
                ctrl.addr_ld  = 1'b1;
                ctrl.addr_sel = as_dest;
                ctrl.we       = 1'b1;
                case (instr.opcode)
                    op_move: begin
                        if (imm_form) begin
                            ctrl.wdata_sel = ws_imm;
                        end else begin
                            ctrl.wdata_sel = ws_b;
                        end
                    end
                    op_in:   ctrl.wdata_sel = ws_in;
                    default: ctrl.wdata_sel = ws_alu;
                endcase
                case (instr.opcode)
                    op_sub:  ctrl.alu_op = alu_sub;
                    op_mul:  ctrl.alu_op = alu_mul;
                    default: ctrl.alu_op = alu_add;
                endcase
                state_nx = st_write;
            end
            st_write: state_nx = st_fetch;  // mem_we high during this state
            st_out_req: begin
                ctrl.addr_ld  = 1'b1;
                ctrl.addr_sel = as_dest;
                state_nx      = st_out_wait;
            end
            st_out_wait: state_nx = st_out;
            st_out: begin
                ctrl.out_ld = 1'b1;
                state_nx    = st_fetch;
            end
            st_halt: state_nx = st_halt;  // left only by reset
            default: state_nx = st_fetch;
        endcase
    end

    assign halted = (state == st_halt);

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  word_t                 mem_rdata,
    input  word_t                 in_data,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic                  mem_we,
    output word_t                 mem_wdata,
    output word_t                 out_data,
    output logic                  halted
);

    ctrl_t  ctrl;
    instr_t instr;
    word_t  imm;
    logic [ADDR_WIDTH-1:0] pc;
    logic   pc_inc;
    logic   ir_ld;
    logic   imm_ld;

    instr_fetch #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_inc    (pc_inc),
        .ir_ld     (ir_ld),
        .imm_ld    (imm_ld),
        .mem_rdata (mem_rdata),
        .instr     (instr),
        .imm       (imm),
        .pc        (pc)
    );

    operand_unit #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_operand (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .instr     (instr),
        .imm       (imm),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .in_data   (in_data),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .out_data  (out_data)
    );

    cpu_control u_control (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (instr),
        .ctrl   (ctrl),
        .pc_inc (pc_inc),
        .ir_ld  (ir_ld),
        .imm_ld (imm_ld),
        .halted (halted)
    );

endmodule

`default_nettype wire

//--- testbench/cpu_chk.sv
`default_nettype none

module cpu_chk #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_we,
    input  logic                  halted,
    input  logic [ADDR_WIDTH-1:0] mem_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // a write lasts exactly one cycle
    we_single: assert property (@(posedge clk) disable iff (!rst_n) mem_we |=> !mem_we)
        else begin
            $error("mem_we stayed high for two cycles in a row");
            fail_count++;
        end

    halt_held: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else begin
            $error("halted fell without a reset");
            fail_count++;
        end

    addr_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(mem_addr))
        else begin
            $error("mem_addr is unknown after reset");
            fail_count++;
        end

endmodule

bind cpu_top cpu_chk #(
    .ADDR_WIDTH(ADDR_WIDTH)
) chk0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_we   (mem_we),
    .halted   (halted),
    .mem_addr (mem_addr)
);

`default_nettype wire

//--- testbench/tb_monitor.sv
`default_nettype none

module tb_monitor import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  halted,
    input  logic  mem_we,
    input  word_t out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;
    int check_count = 0;

    // no write may happen once the CPU sits in halt
    always @(posedge clk) begin
        if (rst_n && halted && mem_we) begin
            $display("ERROR at %0t: mem_we got 1 expected 0 while halted", $time);
            error_count++;
        end
    end

    task automatic check_mem(input int addr, input word_t got, input word_t expected);
        check_count++;
        if (got !== expected) begin
            $display("ERROR at %0t: mem[%0d] got %h expected %h", $time, addr, got, expected);
            error_count++;
        end
    endtask

    // end of a program, output port and halt flag
    task automatic check_end(input word_t expected);
        check_count++;
        if (out_data !== expected) begin
            $display("ERROR at %0t: out_data got %h expected %h", $time, out_data, expected);
            error_count++;
        end
        if (halted !== 1'b1) begin
            $display("ERROR at %0t: halted got %b expected 1", $time, halted);
            error_count++;
        end
    endtask

    task automatic print_summary(input int assert_fails);
        $display("%0d errors, %0d assertion failures, %0d checks",
                 error_count, assert_fails, check_count);
    endtask

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
`default_nettype none

module tb_top import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  addr_width   = 6;
    localparam int  mem_words    = 1 << addr_width;
    localparam int  n_rows       = 11;
    localparam int  prog_words   = 4;
    localparam int  reset_cycles = 5;
    localparam int  max_cycles   = n_rows * (reset_cycles + prog_words * 20 + 10);
    localparam time clk_period   = 100;
    localparam time drive_delay  = 1;

    typedef struct packed {
        logic [0:prog_words-1][word_width-1:0] prog;
        logic [7:0][word_width-1:0]            regs;
        word_t                                 in_data;
        word_t                                 exp_out;
    } row_t;

    // programs at address 8 upward, always ending in STOP
    localparam logic [0:prog_words-1][word_width-1:0] prog_tab [n_rows] = '{
        {16'h0120, 16'hf000, 16'hf000, 16'hf000},  // move direct
        {16'h0308, 16'hbeef, 16'hf000, 16'hf000},  // move immediate
        {16'h1012, 16'hf000, 16'hf000, 16'hf000},  // add
        {16'h2345, 16'hf000, 16'hf000, 16'hf000},  // sub
        {16'h3501, 16'hf000, 16'hf000, 16'hf000},  // mul
        {16'h1ef9, 16'hf000, 16'hf000, 16'hf000},  // add, all three indirect
        {16'h0ef0, 16'hf000, 16'hf000, 16'hf000},  // move indirect
        {16'h7400, 16'h8400, 16'hf000, 16'hf000},  // in then out
        {16'h5123, 16'h8e00, 16'hf000, 16'hf000},  // unused opcode, out indirect
        {16'hc008, 16'h7100, 16'hf000, 16'h7200},  // unused immediate form
        {16'hf000, 16'h7100, 16'h0120, 16'h1012}   // nothing runs past stop
    };

    logic  clk;
    logic  rst_n;
    word_t mem_rdata;
    word_t in_data;
    logic [addr_width-1:0] mem_addr;
    logic  mem_we;
    word_t mem_wdata;
    word_t out_data;
    logic  halted;

    row_t  rows [n_rows];
    word_t mem [mem_words];
    word_t model_mem [mem_words];
    word_t exp_img [n_rows][mem_words];
    int    cycles = 0;

    cpu_top #(
        .ADDR_WIDTH(addr_width)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .in_data   (in_data),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .out_data  (out_data),
        .halted    (halted)
    );

    tb_monitor mon0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .halted   (halted),
        .mem_we   (mem_we),
        .out_data (out_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // synchronous memory, registered read
    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        mem_rdata <= #drive_delay mem[mem_addr];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, halted never rose", cycles);
            mon0.print_summary(dut0.chk0.fail_count);
            $display("Errors found");
            $finish;
        end
    end

    function automatic word_t init_word(int r, int a);
        if (a < start_pc) begin
            return rows[r].regs[a];
        end else if (a < start_pc + prog_words) begin
            return rows[r].prog[a - start_pc];
        end
        return word_t'(16'ha500 + a * 16'h0107);  // fill pattern
    endfunction

    function automatic word_t read_operand(logic ind, logic [2:0] rg);
        word_t ptr;
        ptr = model_mem[rg];
        if (ind) begin
            return model_mem[ptr[addr_width-1:0]];  // word at the held address
        end
        return ptr;
    endfunction

    // instruction set model, one instruction per step
    task automatic run_model(input int r);
        int a;
        int pc;
        int dest;
        int steps;
        word_t w;
        word_t immv;
        word_t b;
        word_t c;
        word_t out;
        logic [3:0] op;
        logic imm_form;
        for (a = 0; a < mem_words; a++) begin
            model_mem[a] = init_word(r, a);
        end
        pc = start_pc;
        out = '0;
        immv = '0;
        for (steps = 0; steps < 2 * prog_words; steps++) begin
            w = model_mem[pc];
            pc = (pc + 1) % mem_words;
            op = w[15:12];
            imm_form = (w[3:0] == 4'b1000);
            if (imm_form) begin
                immv = model_mem[pc];
                pc = (pc + 1) % mem_words;
            end
            if (op == op_stop) begin
                break;
            end
            if (w[11]) begin
                dest = model_mem[w[10:8]][addr_width-1:0];
            end else begin
                dest = w[10:8];
            end
            b = read_operand(w[7], w[6:4]);
            c = read_operand(w[3], w[2:0]);
            case (op)
                op_move: model_mem[dest] = imm_form ? immv : b;
                op_add:  model_mem[dest] = b + c;
                op_sub:  model_mem[dest] = b - c;
                op_mul:  model_mem[dest] = b * c;  // low half of the product
                op_in:   model_mem[dest] = rows[r].in_data;
                op_out:  out = model_mem[dest];
                default: ;
            endcase
        end
        for (a = 0; a < mem_words; a++) begin
            exp_img[r][a] = model_mem[a];
        end
        rows[r].exp_out = out;
    endtask

    task automatic build_table();
        int r;
        int k;
        for (r = 0; r < n_rows; r++) begin
            rows[r].prog = prog_tab[r];
            for (k = 0; k < 6; k++) begin
                rows[r].regs[k] = word_t'($urandom);
            end
            rows[r].regs[6] = word_t'(48 + $urandom % 16);  // pointers into the fill area
            rows[r].regs[7] = word_t'(48 + $urandom % 16);
            rows[r].in_data = word_t'($urandom);
            run_model(r);
        end
    endtask

    task automatic apply_row(input int r);
        int a;
        @(posedge clk);
        #drive_delay;
        rst_n = 1'b0;
        in_data = rows[r].in_data;
        for (a = 0; a < mem_words; a++) begin
            mem[a] = init_word(r, a);
        end
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        do begin
            @(posedge clk);
            #drive_delay;
        end while (!halted);
        repeat (4) @(posedge clk);  // memory has to stay put while halted
        #drive_delay;
        for (a = 0; a < mem_words; a++) begin
            mon0.check_mem(a, mem[a], exp_img[r][a]);
        end
        mon0.check_end(rows[r].exp_out);
    endtask

    initial begin
        int r;
        clk = 1'b0;
        rst_n = 1'b0;
        in_data = '0;
        mem_rdata = '0;
        void'($urandom(32'hec05));
        build_table();
        for (r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        mon0.print_summary(dut0.chk0.fail_count);
        if (mon0.error_count == 0 && dut0.chk0.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/cpu_pkg.sv
design/instr_fetch.sv
design/operand_unit.sv
design/cpu_control.sv
design/cpu_top.sv
testbench/cpu_chk.sv
testbench/tb_monitor.sv
testbench/tb_top.sv
